//--- hw/controller_settings.svh
`ifndef CONTROLLER_SETTINGS_SVH
`define CONTROLLER_SETTINGS_SVH

// ************************************************************
// Control memory map
// ************************************************************
`define CTL_ADDR_FLAGS          8'h00
`define CTL_ADDR_FPGA_STATE     8'h01
`define CTL_ADDR_VERSION_MINOR  8'h02
`define CTL_ADDR_VERSION_MAJOR  8'h03
`define CTL_ADDR_MOD_BASE       8'h20
`define CTL_ADDR_SILENCER_BASE  8'h40
`define CTL_ADDR_SYNC_BASE      8'h50

// Words per settings group, read from the base upward
`define CTL_MOD_WORDS       11
`define CTL_SILENCER_WORDS  5
`define CTL_SYNC_WORDS      4

`define CTL_VERSION_MINOR  8'h01
`define CTL_VERSION_MAJOR  8'hA2

// Bit positions in the flag word
`define CTL_FLAG_MOD_SET       0
`define CTL_FLAG_SILENCER_SET  2
`define CTL_FLAG_FORCE_FAN     4
`define CTL_FLAG_SYNC_SET      8

`define CTL_READ_LATENCY  2

// ************************************************************
// Power-up settings
// ************************************************************
`define CTL_DEF_MOD_REQ_RD_SEGMENT              1'b0
`define CTL_DEF_MOD_CYCLE                       15'd1
`define CTL_DEF_MOD_FREQ_DIV                    32'd5120
`define CTL_DEF_MOD_REP                         32'hFFFF_FFFF
`define CTL_DEF_SILENCER_MODE                   1'b0
`define CTL_DEF_SILENCER_UPDATE_RATE_INTENSITY  16'd256
`define CTL_DEF_SILENCER_UPDATE_RATE_PHASE      16'd256
`define CTL_DEF_SILENCER_STEPS_INTENSITY        16'd10
`define CTL_DEF_SILENCER_STEPS_PHASE            16'd40
`define CTL_DEF_SYNC_TIME                       64'd0

`endif

//--- hw/ctl_bus_pkg.sv
package ctl_bus_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  addr_t;
    typedef logic [3:0]  word_idx_t;   // Word offset inside a group.

    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t wdata;
    } ctl_bus_req_t;

    typedef enum logic [1:0] {
        MOD,
        SILENCER,
        SYNC,
        FLAGS
    } load_group_t;

    // Travels with each read through the latency of the memory.
    typedef struct packed {
        load_group_t group;
        word_idx_t   index;
    } rd_tag_t;

    typedef struct packed {
        logic    valid;
        rd_tag_t tag;
        word_t   data;
    } rd_word_t;

endpackage

//--- hw/ctl_settings_pkg.sv
package ctl_settings_pkg;

    typedef logic [14:0] cycle_t;
    typedef logic [31:0] long_t;        // Frequency division and repeat counts.
    typedef logic [63:0] sync_time_t;

    typedef struct packed {
        logic               thermo;
        logic               stm_segment;
        logic               mod_segment;
        ctl_bus_pkg::word_t stm_cycle;
    } fpga_status_t;

    typedef struct packed {
        logic   update;
        logic   req_rd_segment;
        cycle_t cycle_0;
        long_t  freq_div_0;
        cycle_t cycle_1;
        long_t  freq_div_1;
        long_t  rep_0;
        long_t  rep_1;
    } mod_settings_t;

    typedef struct packed {
        logic               update;
        logic               mode;
        ctl_bus_pkg::word_t update_rate_intensity;
        ctl_bus_pkg::word_t update_rate_phase;
        ctl_bus_pkg::word_t completion_steps_intensity;
        ctl_bus_pkg::word_t completion_steps_phase;
    } silencer_settings_t;

    typedef struct packed {
        logic       update;
        sync_time_t ecat_sync_time;
    } sync_settings_t;

    typedef enum logic [3:0] {
        VERSION_MINOR,
        VERSION_MAJOR,
        POLL_STATUS,
        POLL_FLAGS,
        LOAD_ISSUE,
        LOAD_DRAIN,
        WRITE_FLAGS,
        WRITE_STATUS,
        COMMIT
    } seq_state_t;

endpackage

//--- hw/ctl_read_pipe.sv
`timescale 1ns/1ps
`include "controller_settings.svh"

module ctl_read_pipe #(
    parameter int LATENCY = `CTL_READ_LATENCY
) (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  ctl_bus_pkg::rd_tag_t  issue_tag,
    input  ctl_bus_pkg::word_t    rd_data,
    output ctl_bus_pkg::rd_word_t rd_word
);
    import ctl_bus_pkg::*;

    logic    [LATENCY-1:0] valid_sr;
    rd_tag_t               tag_sr [LATENCY];

    // ************************************************************
    // Tag delay line, one stage per cycle of memory latency
    // ************************************************************
    always_ff @(posedge CLK) begin
        if (reset) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= issue_valid;
            for (int i = 1; i < LATENCY; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    always_ff @(posedge CLK) begin
        tag_sr[0] <= issue_tag;
        for (int i = 1; i < LATENCY; i++) begin
            tag_sr[i] <= tag_sr[i-1];
        end
    end

    // Oldest tag lines up with the word now on the bus.
    always_comb begin
        rd_word.valid = valid_sr[LATENCY-1];
        rd_word.tag   = tag_sr[LATENCY-1];
        rd_word.data  = rd_data;
    end

endmodule

//--- hw/ctl_sequencer.sv
`timescale 1ns/1ps
`include "controller_settings.svh"

module ctl_sequencer (
    input  logic                           CLK,
    input  logic                           reset,
    input  ctl_settings_pkg::fpga_status_t status,
    input  ctl_bus_pkg::rd_word_t          rd_word,
    output ctl_bus_pkg::ctl_bus_req_t      bus_req,
    output logic                           issue_valid,
    output ctl_bus_pkg::rd_tag_t           issue_tag,
    output logic                           commit,
    output ctl_bus_pkg::load_group_t       commit_group,
    output logic                           force_fan
);
    import ctl_bus_pkg::*;
    import ctl_settings_pkg::*;

    seq_state_t  state;
    word_t       flags;
    word_t       status_word;
    load_group_t load_group;
    addr_t       load_base;
    word_idx_t   load_last;
    word_idx_t   issue_idx;
    word_idx_t   rcv_cnt;
    logic        flag_word;
    logic        group_word;
    logic        loading;

    assign status_word = {12'h000, status.stm_cycle == '0, status.stm_segment,
                          status.mod_segment, status.thermo};

    assign flag_word  = rd_word.valid && (rd_word.tag.group == FLAGS);
    assign group_word = rd_word.valid && (rd_word.tag.group == load_group);
    assign loading    = (state == LOAD_ISSUE) || (state == LOAD_DRAIN);

    assign force_fan    = flags[`CTL_FLAG_FORCE_FAN];
    assign commit_group = load_group;

    always_comb begin
        case (load_group)
            MOD: begin
                load_base = `CTL_ADDR_MOD_BASE;
                load_last = word_idx_t'(`CTL_MOD_WORDS - 1);
            end
            SILENCER: begin
                load_base = `CTL_ADDR_SILENCER_BASE;
                load_last = word_idx_t'(`CTL_SILENCER_WORDS - 1);
            end
            default: begin
                load_base = `CTL_ADDR_SYNC_BASE;
                load_last = word_idx_t'(`CTL_SYNC_WORDS - 1);
            end
        endcase
    end

    // ************************************************************
    // Main FSM
    // ************************************************************
    always_ff @(posedge CLK) begin
        if (reset) begin
            state       <= VERSION_MINOR;
            bus_req     <= '0;
            issue_valid <= 1'b0;
            issue_tag   <= '0;
            commit      <= 1'b0;
            flags       <= '0;
            load_group  <= MOD;
            issue_idx   <= '0;
            rcv_cnt     <= '0;
        end else begin
            bus_req.we  <= 1'b0;
            issue_valid <= 1'b0;
            commit      <= 1'b0;

            if (loading && group_word) begin
                rcv_cnt <= rcv_cnt + 1'b1;
            end

            case (state)
                VERSION_MINOR: begin
                    bus_req <= '{we: 1'b1, addr: `CTL_ADDR_VERSION_MINOR,
                                 wdata: {8'h00, `CTL_VERSION_MINOR}};
                    state   <= VERSION_MAJOR;
                end
                VERSION_MAJOR: begin
                    bus_req <= '{we: 1'b1, addr: `CTL_ADDR_VERSION_MAJOR,
                                 wdata: {8'h00, `CTL_VERSION_MAJOR}};
                    state   <= POLL_STATUS;
                end
                POLL_STATUS: begin
                    bus_req   <= '{we: 1'b1, addr: `CTL_ADDR_FPGA_STATE, wdata: status_word};
                    issue_idx <= '0;
                    rcv_cnt   <= '0;
                    if (flags[`CTL_FLAG_MOD_SET]) begin
                        flags[`CTL_FLAG_MOD_SET] <= 1'b0;
                        load_group <= MOD;
                        state      <= LOAD_ISSUE;
                    end else if (flags[`CTL_FLAG_SILENCER_SET]) begin
                        flags[`CTL_FLAG_SILENCER_SET] <= 1'b0;
                        load_group <= SILENCER;
                        state      <= LOAD_ISSUE;
                    end else if (flags[`CTL_FLAG_SYNC_SET]) begin
                        flags[`CTL_FLAG_SYNC_SET] <= 1'b0;
                        load_group <= SYNC;
                        state      <= LOAD_ISSUE;
                    end else begin
                        if (flag_word) begin
                            flags <= rd_word.data;
                        end
                        state <= POLL_FLAGS;
                    end
                end
                POLL_FLAGS: begin
                    bus_req.addr <= `CTL_ADDR_FLAGS;
                    issue_valid  <= 1'b1;
                    issue_tag    <= '{group: FLAGS, index: '0};
                    if (flag_word) begin
                        flags <= rd_word.data;
                    end
                    state <= POLL_STATUS;
                end
                LOAD_ISSUE: begin
                    bus_req.addr <= load_base + addr_t'(issue_idx);
                    issue_valid  <= 1'b1;
                    issue_tag    <= '{group: load_group, index: issue_idx};
                    issue_idx    <= issue_idx + 1'b1;
                    if (issue_idx == load_last) begin
                        state <= LOAD_DRAIN;
                    end
                end
                LOAD_DRAIN: begin
                    if (group_word && (rcv_cnt == load_last)) begin   // Last word is back.
                        state <= WRITE_FLAGS;
                    end
                end
                WRITE_FLAGS: begin
                    bus_req <= '{we: 1'b1, addr: `CTL_ADDR_FLAGS, wdata: flags};
                    state   <= WRITE_STATUS;
                end
                WRITE_STATUS: begin
                    bus_req <= '{we: 1'b1, addr: `CTL_ADDR_FPGA_STATE, wdata: status_word};
                    state   <= COMMIT;
                end
                COMMIT: begin
                    commit <= 1'b1;
                    state  <= POLL_FLAGS;
                end
                default: state <= POLL_STATUS;
            endcase
        end
    end

endmodule

//--- hw/settings_regs.sv
`timescale 1ns/1ps
`include "controller_settings.svh"

module settings_regs (
    input  logic                                 CLK,
    input  logic                                 reset,
    input  ctl_bus_pkg::rd_word_t                rd_word,
    input  logic                                 commit,
    input  ctl_bus_pkg::load_group_t             commit_group,
    output ctl_settings_pkg::mod_settings_t      mod_settings,
    output ctl_settings_pkg::silencer_settings_t silencer_settings,
    output ctl_settings_pkg::sync_settings_t     sync_settings
);
    import ctl_bus_pkg::*;
    import ctl_settings_pkg::*;

    word_t     data;
    word_idx_t idx;

    assign data = rd_word.data;
    assign idx  = rd_word.tag.index;

    always_ff @(posedge CLK) begin
        if (reset) begin
            mod_settings.update         <= 1'b0;
            mod_settings.req_rd_segment <= `CTL_DEF_MOD_REQ_RD_SEGMENT;
            mod_settings.cycle_0        <= `CTL_DEF_MOD_CYCLE;
            mod_settings.freq_div_0     <= `CTL_DEF_MOD_FREQ_DIV;
            mod_settings.cycle_1        <= `CTL_DEF_MOD_CYCLE;
            mod_settings.freq_div_1     <= `CTL_DEF_MOD_FREQ_DIV;
            mod_settings.rep_0          <= `CTL_DEF_MOD_REP;
            mod_settings.rep_1          <= `CTL_DEF_MOD_REP;

            silencer_settings.update                     <= 1'b0;
            silencer_settings.mode                       <= `CTL_DEF_SILENCER_MODE;
            silencer_settings.update_rate_intensity      <= `CTL_DEF_SILENCER_UPDATE_RATE_INTENSITY;
            silencer_settings.update_rate_phase          <= `CTL_DEF_SILENCER_UPDATE_RATE_PHASE;
            silencer_settings.completion_steps_intensity <= `CTL_DEF_SILENCER_STEPS_INTENSITY;
            silencer_settings.completion_steps_phase     <= `CTL_DEF_SILENCER_STEPS_PHASE;

            sync_settings.update         <= 1'b0;
            sync_settings.ecat_sync_time <= `CTL_DEF_SYNC_TIME;
        end else begin
            // Single-cycle update strobes.
            mod_settings.update      <= commit && (commit_group == MOD);
            silencer_settings.update <= commit && (commit_group == SILENCER);
            sync_settings.update     <= commit && (commit_group == SYNC);

            // ************************************************************
            // Word placement by tag
            // ************************************************************
            if (rd_word.valid) begin
                case (rd_word.tag.group)
                    MOD: begin
                        case (idx)
                            4'd0:  mod_settings.req_rd_segment   <= data[0];
                            4'd1:  mod_settings.cycle_0          <= cycle_t'(data);
                            4'd2:  mod_settings.freq_div_0[15:0]  <= data;
                            4'd3:  mod_settings.freq_div_0[31:16] <= data;
                            4'd4:  mod_settings.cycle_1          <= cycle_t'(data);
                            4'd5:  mod_settings.freq_div_1[15:0]  <= data;
                            4'd6:  mod_settings.freq_div_1[31:16] <= data;
                            4'd7:  mod_settings.rep_0[15:0]       <= data;
                            4'd8:  mod_settings.rep_0[31:16]      <= data;
                            4'd9:  mod_settings.rep_1[15:0]       <= data;
                            4'd10: mod_settings.rep_1[31:16]      <= data;
                            default: ;
                        endcase
                    end
                    SILENCER: begin
                        case (idx)
                            4'd0: silencer_settings.mode                       <= data[0];
                            4'd1: silencer_settings.update_rate_intensity      <= data;
                            4'd2: silencer_settings.update_rate_phase          <= data;
                            4'd3: silencer_settings.completion_steps_intensity <= data;
                            4'd4: silencer_settings.completion_steps_phase     <= data;
                            default: ;
                        endcase
                    end
                    SYNC: begin
                        if (idx < 4'd4) begin   // Lowest quarter first.
                            sync_settings.ecat_sync_time[idx[1:0]*16 +: 16] <= data;
                        end
                    end
                    default: ;   // Flag words are the sequencer's.
                endcase
            end
        end
    end

endmodule

//--- hw/controller_top.sv
`timescale 1ns/1ps

module controller_top (
    input  logic                                 CLK,
    input  logic                                 reset,
    input  ctl_settings_pkg::fpga_status_t       status,
    input  ctl_bus_pkg::word_t                   rd_data,
    output ctl_bus_pkg::ctl_bus_req_t            bus_req,
    output ctl_settings_pkg::mod_settings_t      mod_settings,
    output ctl_settings_pkg::silencer_settings_t silencer_settings,
    output ctl_settings_pkg::sync_settings_t     sync_settings,
    output logic                                 force_fan
);
    import ctl_bus_pkg::*;

    rd_word_t    rd_word;
    logic        issue_valid;
    rd_tag_t     issue_tag;
    logic        commit;
    load_group_t commit_group;

    ctl_read_pipe i_read_pipe (
        .CLK         (CLK),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_tag   (issue_tag),
        .rd_data     (rd_data),
        .rd_word     (rd_word)
    );

    ctl_sequencer i_sequencer (
        .CLK          (CLK),
        .reset        (reset),
        .status       (status),
        .rd_word      (rd_word),
        .bus_req      (bus_req),
        .issue_valid  (issue_valid),
        .issue_tag    (issue_tag),
        .commit       (commit),
        .commit_group (commit_group),
        .force_fan    (force_fan)
    );

    settings_regs i_settings_regs (
        .CLK               (CLK),
        .reset             (reset),
        .rd_word           (rd_word),
        .commit            (commit),
        .commit_group      (commit_group),
        .mod_settings      (mod_settings),
        .silencer_settings (silencer_settings),
        .sync_settings     (sync_settings)
    );

endmodule

//--- verification/tb_ctl_mem.sv
`timescale 1ns/1ps
`include "controller_settings.svh"

module tb_ctl_mem #(
    parameter int LATENCY = `CTL_READ_LATENCY
) (
    input  logic                      CLK,
    input  ctl_bus_pkg::ctl_bus_req_t bus_req,
    output ctl_bus_pkg::word_t        rd_data,
    input  logic                      host_we,
    input  ctl_bus_pkg::addr_t        host_addr,
    input  ctl_bus_pkg::word_t        host_wdata,
    output ctl_bus_pkg::word_t        host_rdata
);
    import ctl_bus_pkg::*;

    word_t mem [256];
    word_t rd_pipe [LATENCY];

    initial begin
        for (int a = 0; a < 256; a++) begin
            mem[a] <= {a[7:0] ^ 8'h5A, ~a[7:0]};   // Every address holds its own pattern.
        end
        for (int i = 0; i < LATENCY; i++) begin
            rd_pipe[i] <= '0;
        end
    end

    always @(posedge CLK) begin
        if (bus_req.we) begin
            mem[bus_req.addr] <= bus_req.wdata;
        end
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        rd_pipe[0] <= mem[bus_req.addr];
        for (int i = 1; i < LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign rd_data    = rd_pipe[LATENCY-1];
    assign host_rdata = mem[host_addr];   // Host side reads without latency.

endmodule

//--- verification/tb_controller.sv
`timescale 1ns/1ps
`include "controller_settings.svh"

module tb_controller;
    import ctl_bus_pkg::*;
    import ctl_settings_pkg::*;

    localparam int NUM_ROWS       = 8;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 80 + 200;

    typedef struct packed {
        logic         req_mod;
        logic         req_silencer;
        logic         req_sync;
        logic         fan;
        fpga_status_t status;
    } row_t;

    logic               CLK;
    logic               reset;
    fpga_status_t       status;
    word_t              rd_data;
    ctl_bus_req_t       bus_req;
    mod_settings_t      mod_settings;
    silencer_settings_t silencer_settings;
    sync_settings_t     sync_settings;
    logic               force_fan;
    logic               host_we;
    addr_t              host_addr;
    word_t              host_wdata;
    word_t              host_rdata;

    row_t               rows [NUM_ROWS];
    load_group_t        pending [$];   // Update pulses still owed, in priority order.
    mod_settings_t      exp_mod;
    silencer_settings_t exp_silencer;
    sync_settings_t     exp_sync;
    logic [31:0]        lfsr = 32'h123378e2;
    int                 cycle_count = 0;

    controller_top i_dut (
        .CLK               (CLK),
        .reset             (reset),
        .status            (status),
        .rd_data           (rd_data),
        .bus_req           (bus_req),
        .mod_settings      (mod_settings),
        .silencer_settings (silencer_settings),
        .sync_settings     (sync_settings),
        .force_fan         (force_fan)
    );

    tb_ctl_mem i_mem (
        .CLK        (CLK),
        .bus_req    (bus_req),
        .rd_data    (rd_data),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    // ************************************************************
    // Reference rules and compare tasks
    // ************************************************************
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1.
    endfunction

    function automatic word_t pack_status(input fpga_status_t s);
        word_t w;
        w    = '0;
        w[0] = s.thermo;
        w[1] = s.mod_segment;
        w[2] = s.stm_segment;
        w[3] = (s.stm_cycle == 16'h0000);
        return w;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic compare_field(input string what, input string field,
                                 input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s%s is %0h, expected %0h", $time, what, field, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        compare_field(what, "", 64'(got), 64'(exp));
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        compare_field(what, "", 64'(got), 64'(exp));
    endtask

    task automatic check_mod(input string what, input mod_settings_t got, input mod_settings_t exp);
        compare_field(what, ".update", 64'(got.update), 64'(exp.update));
        compare_field(what, ".req_rd_segment", 64'(got.req_rd_segment), 64'(exp.req_rd_segment));
        compare_field(what, ".cycle_0", 64'(got.cycle_0), 64'(exp.cycle_0));
        compare_field(what, ".freq_div_0", 64'(got.freq_div_0), 64'(exp.freq_div_0));
        compare_field(what, ".cycle_1", 64'(got.cycle_1), 64'(exp.cycle_1));
        compare_field(what, ".freq_div_1", 64'(got.freq_div_1), 64'(exp.freq_div_1));
        compare_field(what, ".rep_0", 64'(got.rep_0), 64'(exp.rep_0));
        compare_field(what, ".rep_1", 64'(got.rep_1), 64'(exp.rep_1));
    endtask

    task automatic check_silencer(input string what, input silencer_settings_t got,
                                  input silencer_settings_t exp);
        compare_field(what, ".update", 64'(got.update), 64'(exp.update));
        compare_field(what, ".mode", 64'(got.mode), 64'(exp.mode));
        compare_field(what, ".update_rate_intensity", 64'(got.update_rate_intensity),
                      64'(exp.update_rate_intensity));
        compare_field(what, ".update_rate_phase", 64'(got.update_rate_phase),
                      64'(exp.update_rate_phase));
        compare_field(what, ".completion_steps_intensity", 64'(got.completion_steps_intensity),
                      64'(exp.completion_steps_intensity));
        compare_field(what, ".completion_steps_phase", 64'(got.completion_steps_phase),
                      64'(exp.completion_steps_phase));
    endtask

    task automatic check_sync(input string what, input sync_settings_t got,
                              input sync_settings_t exp);
        compare_field(what, ".update", 64'(got.update), 64'(exp.update));
        compare_field(what, ".ecat_sync_time", got.ecat_sync_time, exp.ecat_sync_time);
    endtask

    // ************************************************************
    // Cycle stepping, pulse tracking and memory access
    // ************************************************************
    task automatic random_word(output word_t w);
        for (int b = 0; b < 16; b++) begin
            lfsr = lfsr_step(lfsr);
            w[b] = lfsr[0];
        end
    endtask

    task automatic take_pulse(input load_group_t g);
        if (pending.size() == 0 || pending[0] != g) begin
            fail_run($sformatf("Unexpected or repeated %s update pulse.", g.name()));
        end else begin
            void'(pending.pop_front());
        end
    endtask

    task automatic monitor_pulses();
        mod_settings_t      m;
        silencer_settings_t s;
        sync_settings_t     y;
        m        = exp_mod;
        m.update = 1'b1;
        s        = exp_silencer;
        s.update = 1'b1;
        y        = exp_sync;
        y.update = 1'b1;
        if (mod_settings.update) begin
            take_pulse(MOD);
            check_mod("mod settings at pulse", mod_settings, m);
        end
        if (silencer_settings.update) begin
            take_pulse(SILENCER);
            check_silencer("silencer settings at pulse", silencer_settings, s);
        end
        if (sync_settings.update) begin
            take_pulse(SYNC);
            check_sync("sync settings at pulse", sync_settings, y);
        end
    endtask

    task automatic wait_cycle();
        @(posedge CLK);
        #1;
        monitor_pulses();
    endtask

    task automatic write_mem(input addr_t a, input word_t d);
        host_we    = 1'b1;
        host_addr  = a;
        host_wdata = d;
        wait_cycle();
        host_we    = 1'b0;
    endtask

    task automatic read_mem(input addr_t a, output word_t d);
        host_addr = a;
        #1;
        d = host_rdata;
    endtask

    task automatic fill_mod();
        word_t w;
        for (int i = 0; i < `CTL_MOD_WORDS; i++) begin
            random_word(w);
            write_mem(`CTL_ADDR_MOD_BASE + addr_t'(i), w);
            case (i)
                0:  exp_mod.req_rd_segment   = w[0];
                1:  exp_mod.cycle_0          = w[14:0];   // Cycles keep 15 bits.
                2:  exp_mod.freq_div_0[15:0]  = w;
                3:  exp_mod.freq_div_0[31:16] = w;
                4:  exp_mod.cycle_1          = w[14:0];
                5:  exp_mod.freq_div_1[15:0]  = w;
                6:  exp_mod.freq_div_1[31:16] = w;
                7:  exp_mod.rep_0[15:0]       = w;
                8:  exp_mod.rep_0[31:16]      = w;
                9:  exp_mod.rep_1[15:0]       = w;
                default: exp_mod.rep_1[31:16] = w;
            endcase
        end
    endtask

    task automatic fill_silencer();
        word_t w;
        for (int i = 0; i < `CTL_SILENCER_WORDS; i++) begin
            random_word(w);
            write_mem(`CTL_ADDR_SILENCER_BASE + addr_t'(i), w);
            case (i)
                0: exp_silencer.mode                       = w[0];
                1: exp_silencer.update_rate_intensity      = w;
                2: exp_silencer.update_rate_phase          = w;
                3: exp_silencer.completion_steps_intensity = w;
                default: exp_silencer.completion_steps_phase = w;
            endcase
        end
    endtask

    task automatic fill_sync();
        word_t w;
        for (int i = 0; i < `CTL_SYNC_WORDS; i++) begin
            random_word(w);
            write_mem(`CTL_ADDR_SYNC_BASE + addr_t'(i), w);
            exp_sync.ecat_sync_time[i*16 +: 16] = w;   // Lowest quarter first.
        end
    endtask

    task automatic wait_for_pulses();
        int waited;
        int limit;
        waited = 0;
        limit  = 60 * pending.size();
        while (pending.size() > 0 && waited < limit) begin
            wait_cycle();
            waited++;
        end
        if (pending.size() > 0) begin
            fail_run($sformatf("The %s update pulse never arrived.", pending[0].name()));
        end
    endtask

    task automatic run_row(input int r);
        row_t  row;
        word_t flags;
        word_t v;
        row    = rows[r];
        status = row.status;
        if (row.req_mod) begin
            fill_mod();
            pending.push_back(MOD);
        end
        if (row.req_silencer) begin
            fill_silencer();
            pending.push_back(SILENCER);
        end
        if (row.req_sync) begin
            fill_sync();
            pending.push_back(SYNC);
        end
        flags = '0;
        flags[`CTL_FLAG_MOD_SET]      = row.req_mod;
        flags[`CTL_FLAG_SILENCER_SET] = row.req_silencer;
        flags[`CTL_FLAG_SYNC_SET]     = row.req_sync;
        flags[`CTL_FLAG_FORCE_FAN]    = row.fan;
        write_mem(`CTL_ADDR_FLAGS, flags);
        wait_for_pulses();
        repeat (10) wait_cycle();   // Several poll passes.

        flags = '0;
        flags[`CTL_FLAG_FORCE_FAN] = row.fan;
        read_mem(`CTL_ADDR_FLAGS, v);
        check_word("flag word", v, flags);
        read_mem(`CTL_ADDR_FPGA_STATE, v);
        check_word("status word", v, pack_status(row.status));
        check_bit("force_fan", force_fan, row.fan);
        check_mod("mod settings", mod_settings, exp_mod);
        check_silencer("silencer settings", silencer_settings, exp_silencer);
        check_sync("sync settings", sync_settings, exp_sync);
    endtask

    initial begin
        word_t v;
        reset      = 1'b1;
        status     = '0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;

        exp_mod.update                          = 1'b0;
        exp_mod.req_rd_segment                  = `CTL_DEF_MOD_REQ_RD_SEGMENT;
        exp_mod.cycle_0                         = `CTL_DEF_MOD_CYCLE;
        exp_mod.freq_div_0                      = `CTL_DEF_MOD_FREQ_DIV;
        exp_mod.cycle_1                         = `CTL_DEF_MOD_CYCLE;
        exp_mod.freq_div_1                      = `CTL_DEF_MOD_FREQ_DIV;
        exp_mod.rep_0                           = `CTL_DEF_MOD_REP;
        exp_mod.rep_1                           = `CTL_DEF_MOD_REP;
        exp_silencer.update                     = 1'b0;
        exp_silencer.mode                       = `CTL_DEF_SILENCER_MODE;
        exp_silencer.update_rate_intensity      = `CTL_DEF_SILENCER_UPDATE_RATE_INTENSITY;
        exp_silencer.update_rate_phase          = `CTL_DEF_SILENCER_UPDATE_RATE_PHASE;
        exp_silencer.completion_steps_intensity = `CTL_DEF_SILENCER_STEPS_INTENSITY;
        exp_silencer.completion_steps_phase     = `CTL_DEF_SILENCER_STEPS_PHASE;
        exp_sync.update                         = 1'b0;
        exp_sync.ecat_sync_time                 = `CTL_DEF_SYNC_TIME;

        // mod, silencer, sync, fan, {thermo, stm_segment, mod_segment, stm_cycle}
        rows[0] = '{1'b0, 1'b0, 1'b0, 1'b0, '{1'b0, 1'b0, 1'b0, 16'h0000}};
        rows[1] = '{1'b1, 1'b0, 1'b0, 1'b0, '{1'b1, 1'b0, 1'b0, 16'h0005}};
        rows[2] = '{1'b0, 1'b1, 1'b0, 1'b1, '{1'b0, 1'b1, 1'b0, 16'h0000}};
        rows[3] = '{1'b0, 1'b0, 1'b1, 1'b1, '{1'b0, 1'b0, 1'b1, 16'h8000}};
        rows[4] = '{1'b1, 1'b0, 1'b1, 1'b0, '{1'b1, 1'b1, 1'b1, 16'h0001}};
        rows[5] = '{1'b0, 1'b0, 1'b0, 1'b1, '{1'b1, 1'b0, 1'b1, 16'h0000}};
        rows[6] = '{1'b0, 1'b1, 1'b1, 1'b0, '{1'b0, 1'b1, 1'b1, 16'h1234}};
        rows[7] = '{1'b1, 1'b1, 1'b1, 1'b0, '{1'b0, 1'b0, 1'b0, 16'hFFFF}};

        @(posedge CLK);
        #1;
        write_mem(`CTL_ADDR_FLAGS, 16'h0000);   // Clear the fill pattern's flag bits.
        reset = 1'b0;

        check_mod("mod settings after reset", mod_settings, exp_mod);
        check_silencer("silencer settings after reset", silencer_settings, exp_silencer);
        check_sync("sync settings after reset", sync_settings, exp_sync);
        check_bit("force_fan after reset", force_fan, 1'b0);
        check_bit("bus write enable after reset", bus_req.we, 1'b0);

        repeat (4) wait_cycle();
        read_mem(`CTL_ADDR_VERSION_MINOR, v);
        check_word("version minor", v, {8'h00, `CTL_VERSION_MINOR});
        read_mem(`CTL_ADDR_VERSION_MAJOR, v);
        check_word("version major", v, {8'h00, `CTL_VERSION_MAJOR});

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/ctl_bus_pkg.sv
hw/ctl_settings_pkg.sv
hw/ctl_read_pipe.sv
hw/ctl_sequencer.sv
hw/settings_regs.sv
hw/controller_top.sv
verification/tb_ctl_mem.sv
verification/tb_controller.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -f project.f \
        --top-module tb_controller -o sim_controller \
    && ./obj_dir/sim_controller \
    || exit 1
